// ==== Bender.yml ====
package:
  name: icache_fetch

sources:
  - include_dirs:
      - hw
    files:
      - hw/fetch_pkg.sv
      - hw/ram1r1w.sv
      - hw/predecode.sv
      - hw/pattern_table.sv
      - hw/fetch_control.sv
      - hw/fetch_queue.sv
      - hw/icache_fetch.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - dv/imem_model.sv
      - dv/icache_fetch_tb.sv

// ==== build.f ====
+incdir+hw
hw/fetch_pkg.sv
hw/ram1r1w.sv
hw/predecode.sv
hw/pattern_table.sv
hw/fetch_control.sv
hw/fetch_queue.sv
hw/icache_fetch.sv
dv/imem_model.sv
dv/icache_fetch_tb.sv

// ==== dv/icache_fetch_tb.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module icache_fetch_tb import fetch_pkg::*; ();

   localparam int EXPECTED_INSNS = 153;
   localparam int TIMEOUT_CYCLES = 16 + (1 << `LG_PHT_ENTRIES) + 200 * EXPECTED_INSNS;

   logic  clk, reset;
   logic  restart_valid, restart_ack;
   addr_t restart_pc;
   logic  mem_req_valid, mem_rsp_valid;
   addr_t mem_req_addr;
   line_t mem_rsp_data;
   logic  branch_update_valid, branch_taken;
   addr_t branch_update_pc;
   logic  insn_valid, insn_pred, insn_ack;
   addr_t insn_pc, insn_pred_target;
   word_t insn_data;

   // reference model state
   pht_ctr_t ref_ctr [0:(1 << `LG_PHT_ENTRIES)-1];
   addr_t    model_pc, redirect_target, target_pc, first_pc, watch_pc;
   logic     in_delay, first_pending, watch_seen, watch_pred;
   logic     ack_enable, ack_slow, ack_phase;
   logic     mem_busy;
   int       pops_since_ack, value_errors, other_errors;
   string    test_name;

   icache_fetch i_dut
   (
      .clk                 (clk),
      .reset               (reset),
      .restart_valid       (restart_valid),
      .restart_pc          (restart_pc),
      .restart_ack         (restart_ack),
      .mem_req_valid       (mem_req_valid),
      .mem_req_addr        (mem_req_addr),
      .mem_rsp_valid       (mem_rsp_valid),
      .mem_rsp_data        (mem_rsp_data),
      .branch_update_valid (branch_update_valid),
      .branch_update_pc    (branch_update_pc),
      .branch_taken        (branch_taken),
      .insn_valid          (insn_valid),
      .insn_pc             (insn_pc),
      .insn_data           (insn_data),
      .insn_pred           (insn_pred),
      .insn_pred_target    (insn_pred_target),
      .insn_ack            (insn_ack)
   );

   imem_model i_imem
   (
      .clk       (clk),
      .reset     (reset),
      .req_valid (mem_req_valid),
      .req_addr  (mem_req_addr),
      .rsp_valid (mem_rsp_valid),
      .rsp_data  (mem_rsp_data)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #10 clk = ~clk;
      end
   end

   function automatic word_t reorder_bytes(word_t w);
      return {w[7:0], w[15:8], w[23:16], w[31:24]};
   endfunction

   // expected prediction for one instruction outside a delay slot
   function automatic void ref_next_pc(input addr_t pc, input word_t insn, input pht_ctr_t ctr,
                                       output logic pred, output addr_t target);
      addr_t br_target;
      logic  is_jump, is_taken_br, is_cond;
      br_target = pc + 32'd4 + {{14{insn[15]}}, insn[15:0], 2'b00};
      is_jump = (insn[31:26] == 6'h02) || (insn[31:26] == 6'h03);
      is_taken_br = 1'b0;
      is_cond = 1'b0;
      case (insn[31:26])
         6'h01:
         begin
            is_cond = (insn[20:16] == 5'h00) || (insn[20:16] == 5'h01);
            is_taken_br = (insn[20:16] == 5'h02) || (insn[20:16] == 5'h03);
         end
         6'h04:
         begin
            is_taken_br = (insn[25:16] == 10'd0);
            is_cond = !is_taken_br;
         end
         6'h05, 6'h06, 6'h07:
         begin
            is_cond = 1'b1;
         end
         6'h11:
         begin
            is_taken_br = (insn[25:21] == 5'h08) && insn[17];
            is_cond = (insn[25:21] == 5'h08) && !insn[17];
         end
         6'h14, 6'h15, 6'h16, 6'h17:
         begin
            is_taken_br = 1'b1;
         end
         default:
         begin
            is_cond = 1'b0;
         end
      endcase
      if (is_cond)
      begin
         is_taken_br = ctr[1];
      end
      pred = is_jump || is_taken_br;
      if (is_jump)
      begin
         target = {pc[31:28], insn[25:0], 2'b00};
      end
      else if (is_taken_br)
      begin
         target = br_target;
      end
      else
      begin
         target = pc + 32'd4;
      end
   endfunction

   task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
      if (expected !== actual)
      begin
         value_errors++;
         $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic check_word(input string name, input word_t expected, input word_t actual);
      if (expected !== actual)
      begin
         value_errors++;
         $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic check_flag(input string name, input bit expected, input logic actual);
      if (expected !== actual)
      begin
         value_errors++;
         $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
      end
   endtask

   // compare every popped entry against the reference stream
   always @(negedge clk)
   begin
      word_t exp_insn;
      logic  exp_pred;
      addr_t exp_target;
      if (!reset)
      begin
         if (restart_ack)
         begin
            model_pc = target_pc;
            in_delay = 1'b0;
            pops_since_ack = 0;
            first_pending = 1'b1;
         end
         if (insn_valid && insn_ack)
         begin
            exp_insn = reorder_bytes(i_imem.image[model_pc[11:2]]);
            if (in_delay)
            begin
               exp_pred = 1'b0;
               exp_target = model_pc + 32'd4;
            end
            else
            begin
               ref_next_pc(model_pc, exp_insn, ref_ctr[model_pc[`LG_PHT_ENTRIES+1:2]],
                           exp_pred, exp_target);
            end
            check_addr({test_name, " insn_pc"}, model_pc, insn_pc);
            check_word({test_name, " insn_data"}, exp_insn, insn_data);
            check_flag({test_name, " insn_pred"}, exp_pred, insn_pred);
            check_addr({test_name, " insn_pred_target"}, exp_target, insn_pred_target);
            if (first_pending)
            begin
               first_pc = insn_pc;
               first_pending = 1'b0;
            end
            if (insn_pc == watch_pc)
            begin
               watch_seen = 1'b1;
               watch_pred = insn_pred;
            end
            // delay slot first, then the redirect
            if (in_delay)
            begin
               model_pc = redirect_target;
               in_delay = 1'b0;
            end
            else
            begin
               if (exp_pred)
               begin
                  redirect_target = exp_target;
                  in_delay = 1'b1;
               end
               model_pc = model_pc + 32'd4;
            end
            pops_since_ack++;
         end
      end
   end

   // one line-aligned memory request at a time
   always @(negedge clk)
   begin
      if (reset)
      begin
         mem_busy = 1'b0;
      end
      else
      begin
         if (mem_req_valid)
         begin
            if (mem_busy)
            begin
               other_errors++;
               $display("a memory request was issued while another was still outstanding");
            end
            if (mem_req_addr[`LG_LINE_BYTES-1:0] != '0)
            begin
               other_errors++;
               $display("memory request address %h is not aligned to a line", mem_req_addr);
            end
            mem_busy = 1'b1;
         end
         if (mem_rsp_valid)
         begin
            mem_busy = 1'b0;
         end
      end
   end

   // decoder side acks
   initial
   begin
      ack_phase = 1'b0;
      forever
      begin
         @(posedge clk);
         #2;
         ack_phase = ~ack_phase;
         insn_ack = ack_enable && (!ack_slow || ack_phase);
      end
   end

   task automatic plant_insn(input addr_t addr, input word_t insn);
      i_imem.write_word(addr, reorder_bytes(insn));
   endtask

   task automatic plant_branches();
      plant_insn(32'h208, 32'h080000c0);
      plant_insn(32'h30c, 32'h0c000100);
      plant_insn(32'h504, 32'h1000003e);
      plant_insn(32'h608, 32'h5022003d);
      plant_insn(32'h704, 32'h04a2ff8e);
      plant_insn(32'h548, 32'h450200ad);
      plant_insn(32'h904, 32'h1464003e);
      plant_insn(32'h910, 32'h45000010);
      plant_insn(32'h918, 32'h04c10008);
      plant_insn(32'h920, 32'h18e00004);
      plant_insn(32'hb10, 32'h08000300);
   endtask

   task automatic restart_to(input addr_t pc);
      target_pc = pc;
      @(posedge clk);
      #2;
      restart_valid = 1'b1;
      restart_pc = pc;
      @(posedge clk);
      #2;
      restart_valid = 1'b0;
      do
      begin
         @(negedge clk);
      end
      while (!restart_ack);
      @(posedge clk);
   endtask

   task automatic wait_pops(input int n);
      while (pops_since_ack < n)
      begin
         @(negedge clk);
      end
   endtask

   task automatic run_stream(input string name, input addr_t pc, input int n);
      test_name = name;
      restart_to(pc);
      ack_enable = 1'b1;
      wait_pops(n);
      ack_enable = 1'b0;
      repeat (3) @(posedge clk);
   endtask

   task automatic send_update(input addr_t pc, input logic taken);
      @(posedge clk);
      #2;
      branch_update_valid = 1'b1;
      branch_update_pc = pc;
      branch_taken = taken;
      @(posedge clk);
      #2;
      branch_update_valid = 1'b0;
      if (taken && (ref_ctr[pc[`LG_PHT_ENTRIES+1:2]] != 2'd3))
      begin
         ref_ctr[pc[`LG_PHT_ENTRIES+1:2]]++;
      end
      else if (!taken && (ref_ctr[pc[`LG_PHT_ENTRIES+1:2]] != 2'd0))
      begin
         ref_ctr[pc[`LG_PHT_ENTRIES+1:2]]--;
      end
   endtask

   task automatic run_cond(input string name, input bit expected);
      watch_seen = 1'b0;
      run_stream(name, 32'h900, 12);
      if (!watch_seen)
      begin
         other_errors++;
         $display("%s: the branch at %h was never popped", name, watch_pc);
      end
      check_flag({name, " branch prediction"}, expected, watch_pred);
   endtask

   task automatic print_summary();
      $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
   endtask

   initial
   begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      other_errors++;
      $display("watchdog expired after %0d cycles with the run unfinished", TIMEOUT_CYCLES);
      print_summary();
      $display("=== FAIL ===");
      $finish;
   end

   initial
   begin
      reset = 1'b1;
      restart_valid = 1'b0;
      restart_pc = '0;
      branch_update_valid = 1'b0;
      branch_update_pc = '0;
      branch_taken = 1'b0;
      insn_ack = 1'b0;
      ack_enable = 1'b0;
      ack_slow = 1'b0;
      in_delay = 1'b0;
      first_pending = 1'b0;
      watch_pc = 32'h904;
      watch_seen = 1'b0;
      watch_pred = 1'b0;
      mem_busy = 1'b0;
      model_pc = '0;
      target_pc = '0;
      pops_since_ack = 0;
      value_errors = 0;
      other_errors = 0;
      test_name = "reset";
      for (int i = 0; i < (1 << `LG_PHT_ENTRIES); i++)
      begin
         ref_ctr[i] = 2'd1;
      end
      #1;
      plant_branches();
      repeat (16) @(posedge clk);
      #2;
      reset = 1'b0;

      run_stream("cold_sequential", 32'h100, 24);
      run_stream("jump_call", 32'h200, 20);
      run_stream("likely_always", 32'h500, 28);

      // fresh, then trained taken, then trained back
      run_cond("cond_fresh", 1'b0);
      send_update(32'h904, 1'b1);
      send_update(32'h904, 1'b1);
      repeat (4) @(posedge clk);
      run_cond("cond_trained_taken", 1'b1);
      send_update(32'h904, 1'b0);
      send_update(32'h904, 1'b0);
      repeat (4) @(posedge clk);
      run_cond("cond_trained_not_taken", 1'b0);

      test_name = "back_pressure";
      restart_to(32'hb00);
      while (!i_dut.i_fetch_queue.full)
      begin
         @(negedge clk);
      end
      ack_slow = 1'b1;
      ack_enable = 1'b1;
      wait_pops(30);
      ack_enable = 1'b0;
      ack_slow = 1'b0;
      repeat (3) @(posedge clk);

      test_name = "midstream_restart";
      restart_to(32'hd00);
      ack_enable = 1'b1;
      wait_pops(5);
      restart_to(32'he40);
      wait_pops(10);
      ack_enable = 1'b0;
      check_addr("midstream_restart first pc", 32'he40, first_pc);

      print_summary();
      if ((value_errors == 0) && (other_errors == 0))
      begin
         $display("=== PASS ===");
      end
      else
      begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// ==== dv/imem_model.sv ====
`timescale 1ns/1ps

module imem_model import fetch_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  logic  req_valid,
   input  addr_t req_addr,
   output logic  rsp_valid,
   output line_t rsp_data
);

   localparam int LG_WORDS = 10;

   // big-endian image, addresses alias every 4 KB
   word_t       image [0:(1 << LG_WORDS)-1];
   logic [31:0] lfsr_state;

   // fibonacci lfsr, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
   endtask

   task automatic write_word(input addr_t addr, input word_t w);
      image[addr[LG_WORDS+1:2]] = w;
   endtask

   initial
   begin
      logic [31:0] r;
      lfsr_state = 32'h1f72;
      rsp_valid = 1'b0;
      rsp_data = '0;
      for (int idx = 0; idx < (1 << LG_WORDS); idx++)
      begin
         take_bits(32, r);
         // opcode zero keeps every filler word out of the branch classes
         r[31:26] = 6'd0;
         image[idx] = {r[7:0], r[15:8], r[23:16], r[31:24]};
      end
   end

   always
   begin
      addr_t                base;
      logic [31:0]          delay;
      logic [LG_WORDS-1:0]  widx;
      line_t                line;
      @(negedge clk);
      if (!reset && req_valid)
      begin
         base = req_addr;
         take_bits(3, delay);
         repeat (delay + 1) @(posedge clk);
         #2;
         for (int i = 0; i < 4; i++)
         begin
            widx = {base[LG_WORDS+1:4], 2'(i)};
            line[32*i +: 32] = image[widx];
         end
         rsp_data = line;
         rsp_valid = 1'b1;
         @(posedge clk);
         #2;
         rsp_valid = 1'b0;
      end
   end

endmodule

// ==== hw/fetch_cfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// fetch address width in bits
`define FETCH_ADDR_W 32

// log2 of the cache line size in bytes
// 16-byte lines hold four instruction words
`define LG_LINE_BYTES 4

// log2 of the number of direct-mapped sets
`define LG_NUM_SETS 6

// log2 of the fetch queue depth
`define LG_FQ_ENTRIES 3

// log2 of the pattern table size
`define LG_PHT_ENTRIES 10

`endif

// ==== hw/fetch_control.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_control import fetch_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     restart_valid,
   input  addr_t    restart_pc,
   output logic     restart_ack,
   output logic     mem_req_valid,
   output addr_t    mem_req_addr,
   input  logic     mem_rsp_valid,
   input  line_t    mem_rsp_data,
   output addr_t    pred_addr,
   input  pht_ctr_t pred_ctr,
   input  logic     table_ready,
   output logic     push,
   output addr_t    push_pc,
   output word_t    push_data,
   output logic     push_pred,
   output addr_t    push_pred_target,
   output logic     clear,
   input  logic     full
);

   localparam int WORDS = 1 << (`LG_LINE_BYTES - 2);
   localparam int NUM_SETS = 1 << `LG_NUM_SETS;
   localparam int IDX_LO = `LG_LINE_BYTES;
   localparam int IDX_HI = `LG_LINE_BYTES + `LG_NUM_SETS - 1;
   localparam int TAG_W = `FETCH_ADDR_W - IDX_HI - 1;
   localparam int SEXT_W = `FETCH_ADDR_W - 18;

   fetch_state_t r_state, n_state;
   addr_t        r_pc, n_pc;
   addr_t        r_cache_pc, n_cache_pc;
   addr_t        r_miss_pc, n_miss_pc;
   addr_t        r_mem_req_addr, n_mem_req_addr;
   addr_t        r_restart_pc, t_restart_target;
   addr_t        t_jump_target, t_branch_target;
   logic         r_req, n_req;
   logic         r_restart_req, n_restart_req;
   logic         r_restart_ack, n_restart_ack;
   logic         r_mem_req_valid, n_mem_req_valid;
   logic         r_delay_slot, n_delay_slot;

   logic [NUM_SETS-1:0]       r_valid;
   logic                      r_valid_out;
   logic [`LG_NUM_SETS-1:0]   t_cache_idx, t_refill_idx;
   logic [TAG_W-1:0]          r_tag_out;
   line_t                     r_line_out, t_swapped_line;
   logic [4*WORDS-1:0]        r_class_out, t_refill_class;
   logic [`LG_LINE_BYTES-3:0] t_word_idx;
   word_t                     t_word;
   pd_class_t                 t_class;
   logic                      t_hit, t_miss, t_take, t_push, t_clear, t_refill;

   assign t_hit = r_req && r_valid_out && (r_tag_out == r_cache_pc[`FETCH_ADDR_W-1:IDX_HI+1]);
   assign t_miss = r_req && !t_hit;
   assign t_refill = mem_rsp_valid && (r_state == st_wait_refill);
   assign t_refill_idx = r_mem_req_addr[IDX_HI:IDX_LO];
   assign t_restart_target = restart_valid ? restart_pc : r_restart_pc;

   assign restart_ack = r_restart_ack;
   assign mem_req_valid = r_mem_req_valid;
   assign mem_req_addr = r_mem_req_addr;
   assign pred_addr = n_cache_pc;
   assign push = t_push;
   assign push_pc = r_cache_pc;
   assign push_data = t_word;
   assign push_pred = t_take;
   assign clear = t_clear;

   // second stage word select and next-pc prediction
   always_comb
   begin
      t_word_idx = r_cache_pc[IDX_LO-1:2];
      t_word = r_line_out[32*t_word_idx +: 32];
      t_class = pd_class_t'(r_class_out[4*t_word_idx +: 4]);
      t_jump_target = {r_cache_pc[`FETCH_ADDR_W-1:28], t_word[25:0], 2'b00};
      t_branch_target = r_cache_pc + 'd4 + {{SEXT_W{t_word[15]}}, t_word[15:0], 2'b00};
      t_take = 1'b0;
      push_pred_target = r_cache_pc + 'd4;
      // a delay slot never redirects since its target is already in flight
      if (!r_delay_slot)
      begin
         case (t_class)
            pd_jump, pd_call:
            begin
               t_take = 1'b1;
               push_pred_target = t_jump_target;
            end
            pd_likely, pd_always:
            begin
               t_take = 1'b1;
               push_pred_target = t_branch_target;
            end
            pd_cond:
            begin
               t_take = pred_ctr[1];
               push_pred_target = pred_ctr[1] ? t_branch_target : r_cache_pc + 'd4;
            end
            default:
            begin
               t_take = 1'b0;
            end
         endcase
      end
   end

   always_comb
   begin
      n_state = r_state;
      n_pc = r_pc;
      n_cache_pc = r_cache_pc;
      n_miss_pc = r_miss_pc;
      n_mem_req_addr = r_mem_req_addr;
      n_req = 1'b0;
      n_mem_req_valid = 1'b0;
      n_restart_ack = 1'b0;
      n_restart_req = restart_valid | r_restart_req;
      n_delay_slot = r_delay_slot;
      t_cache_idx = r_pc[IDX_HI:IDX_LO];
      t_push = 1'b0;
      // restart is taken once the table is ready and no refill is in flight
      t_clear = n_restart_req && (r_state inside {st_idle, st_active, st_refill_turn,
                                                  st_wait_not_full});
      if (t_clear)
      begin
         n_restart_ack = 1'b1;
         n_restart_req = 1'b0;
         n_pc = t_restart_target;
         n_delay_slot = 1'b0;
         n_state = st_active;
      end
      else
      begin
         case (r_state)
            st_init:
            begin
               if (table_ready)
               begin
                  n_state = st_idle;
               end
            end
            st_idle:
            begin
               // only a restart leaves idle
               n_state = st_idle;
            end
            st_active:
            begin
               n_cache_pc = r_pc;
               n_req = 1'b1;
               n_pc = r_pc + 'd4;
               if (t_miss || (t_hit && full))
               begin
                  // drop the access just issued and reissue r_pc later
                  n_req = 1'b0;
                  n_pc = r_pc;
                  n_miss_pc = r_cache_pc;
                  n_state = full && t_hit ? st_wait_not_full : st_wait_refill;
                  n_mem_req_valid = t_miss;
                  if (t_miss)
                  begin
                     n_mem_req_addr = {r_cache_pc[`FETCH_ADDR_W-1:IDX_LO], {IDX_LO{1'b0}}};
                  end
               end
               else if (t_hit)
               begin
                  t_push = 1'b1;
                  n_delay_slot = t_take;
                  if (t_take)
                  begin
                     n_pc = push_pred_target;
                  end
               end
            end
            st_wait_refill:
            begin
               if (t_refill)
               begin
                  n_state = st_refill_turn;
               end
            end
            st_refill_turn, st_wait_not_full:
            begin
               t_cache_idx = r_miss_pc[IDX_HI:IDX_LO];
               n_cache_pc = r_miss_pc;
               if ((r_state == st_refill_turn) || !full)
               begin
                  n_req = 1'b1;
                  n_state = st_active;
               end
            end
            default:
            begin
               n_state = st_init;
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= st_init;
         r_req <= 1'b0;
         r_restart_req <= 1'b0;
         r_restart_ack <= 1'b0;
         r_mem_req_valid <= 1'b0;
         r_delay_slot <= 1'b0;
         r_valid <= '0;
      end
      else
      begin
         r_state <= n_state;
         r_req <= n_req;
         r_restart_req <= n_restart_req;
         r_restart_ack <= n_restart_ack;
         r_mem_req_valid <= n_mem_req_valid;
         r_delay_slot <= n_delay_slot;
         if (t_refill)
         begin
            r_valid[t_refill_idx] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      r_pc <= n_pc;
      r_cache_pc <= n_cache_pc;
      r_miss_pc <= n_miss_pc;
      r_mem_req_addr <= n_mem_req_addr;
      r_valid_out <= r_valid[t_cache_idx];
      if (restart_valid)
      begin
         r_restart_pc <= restart_pc;
      end
   end

   // swap and classify each word of the refill line
   for (genvar i = 0; i < WORDS; i++)
   begin : g_refill
      pd_class_t w_class;
      predecode i_predecode
      (
         .mem_word (mem_rsp_data[32*i +: 32]),
         .pd_class (w_class)
      );
      assign t_refill_class[4*i +: 4] = w_class;
      assign t_swapped_line[32*i +: 32] = byte_swap(mem_rsp_data[32*i +: 32]);
   end

   ram1r1w #(.WIDTH(TAG_W), .LG_DEPTH(`LG_NUM_SETS)) tag_array
   (
      .clk     (clk),
      .rd_addr (t_cache_idx),
      .wr_addr (t_refill_idx),
      .wr_data (r_mem_req_addr[`FETCH_ADDR_W-1:IDX_HI+1]),
      .wr_en   (t_refill),
      .rd_data (r_tag_out)
   );

   ram1r1w #(.WIDTH($bits(line_t)), .LG_DEPTH(`LG_NUM_SETS)) data_array
   (
      .clk     (clk),
      .rd_addr (t_cache_idx),
      .wr_addr (t_refill_idx),
      .wr_data (t_swapped_line),
      .wr_en   (t_refill),
      .rd_data (r_line_out)
   );

   ram1r1w #(.WIDTH(4*WORDS), .LG_DEPTH(`LG_NUM_SETS)) class_array
   (
      .clk     (clk),
      .rd_addr (t_cache_idx),
      .wr_addr (t_refill_idx),
      .wr_data (t_refill_class),
      .wr_en   (t_refill),
      .rd_data (r_class_out)
   );

endmodule

// ==== hw/fetch_pkg.sv ====
`include "fetch_cfg.svh"

package fetch_pkg;

   typedef logic [`FETCH_ADDR_W-1:0] addr_t;
   typedef logic [31:0] word_t;
   typedef logic [(8 << `LG_LINE_BYTES)-1:0] line_t;

   // 2-bit saturating counter, taken when the top bit is set
   typedef logic [1:0] pht_ctr_t;

   // control-flow class stored next to each cached word
   typedef enum logic [3:0]
   {
      pd_none   = 4'd0,
      pd_cond   = 4'd1,
      pd_likely = 4'd2,
      pd_jump   = 4'd3,
      pd_call   = 4'd5,
      pd_always = 4'd8
   } pd_class_t;

   typedef enum logic [2:0]
   {
      st_init,
      st_idle,
      st_active,
      st_wait_refill,
      st_refill_turn,
      st_wait_not_full
   } fetch_state_t;

   // memory words arrive big-endian
   function automatic word_t byte_swap(word_t w);
      return {w[7:0], w[15:8], w[23:16], w[31:24]};
   endfunction

endpackage

// ==== hw/fetch_queue.sv ====
`timescale 1ns/1ps

module fetch_queue import fetch_pkg::*;
#(
   parameter int LG_ENTRIES = 3
)
(
   input  logic  clk,
   input  logic  reset,
   input  logic  clear,
   input  logic  push,
   input  addr_t push_pc,
   input  word_t push_data,
   input  logic  push_pred,
   input  addr_t push_pred_target,
   output logic  full,
   input  logic  insn_ack,
   output logic  insn_valid,
   output addr_t insn_pc,
   output word_t insn_data,
   output logic  insn_pred,
   output addr_t insn_pred_target
);

   localparam int ENTRIES = 1 << LG_ENTRIES;

   addr_t r_pc     [0:ENTRIES-1];
   word_t r_data   [0:ENTRIES-1];
   logic  r_pred   [0:ENTRIES-1];
   addr_t r_target [0:ENTRIES-1];

   // extra top bit tells a full ring from an empty one
   logic [LG_ENTRIES:0] r_head, r_tail;
   logic                t_write, t_pop;

   assign insn_valid = (r_head != r_tail);
   assign full = (r_head[LG_ENTRIES] != r_tail[LG_ENTRIES]) &&
                 (r_head[LG_ENTRIES-1:0] == r_tail[LG_ENTRIES-1:0]);
   assign t_write = push && !full;
   assign t_pop = insn_ack && insn_valid;

   assign insn_pc = r_pc[r_head[LG_ENTRIES-1:0]];
   assign insn_data = r_data[r_head[LG_ENTRIES-1:0]];
   assign insn_pred = r_pred[r_head[LG_ENTRIES-1:0]];
   assign insn_pred_target = r_target[r_head[LG_ENTRIES-1:0]];

   always_ff @(posedge clk)
   begin
      if (reset || clear)
      begin
         r_head <= '0;
         r_tail <= '0;
      end
      else
      begin
         r_head <= r_head + t_pop;
         r_tail <= r_tail + t_write;
      end
   end

   always_ff @(posedge clk)
   begin
      if (t_write)
      begin
         r_pc[r_tail[LG_ENTRIES-1:0]] <= push_pc;
         r_data[r_tail[LG_ENTRIES-1:0]] <= push_data;
         r_pred[r_tail[LG_ENTRIES-1:0]] <= push_pred;
         r_target[r_tail[LG_ENTRIES-1:0]] <= push_pred_target;
      end
   end

endmodule

// ==== hw/icache_fetch.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module icache_fetch import fetch_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  logic  restart_valid,
   input  addr_t restart_pc,
   output logic  restart_ack,
   output logic  mem_req_valid,
   output addr_t mem_req_addr,
   input  logic  mem_rsp_valid,
   input  line_t mem_rsp_data,
   input  logic  branch_update_valid,
   input  addr_t branch_update_pc,
   input  logic  branch_taken,
   output logic  insn_valid,
   output addr_t insn_pc,
   output word_t insn_data,
   output logic  insn_pred,
   output addr_t insn_pred_target,
   input  logic  insn_ack
);

   addr_t    pred_addr, push_pc, push_pred_target;
   pht_ctr_t pred_ctr;
   word_t    push_data;
   logic     table_ready, push, push_pred, clear, full;

   fetch_control i_fetch_control
   (
      .clk              (clk),
      .reset            (reset),
      .restart_valid    (restart_valid),
      .restart_pc       (restart_pc),
      .restart_ack      (restart_ack),
      .mem_req_valid    (mem_req_valid),
      .mem_req_addr     (mem_req_addr),
      .mem_rsp_valid    (mem_rsp_valid),
      .mem_rsp_data     (mem_rsp_data),
      .pred_addr        (pred_addr),
      .pred_ctr         (pred_ctr),
      .table_ready      (table_ready),
      .push             (push),
      .push_pc          (push_pc),
      .push_data        (push_data),
      .push_pred        (push_pred),
      .push_pred_target (push_pred_target),
      .clear            (clear),
      .full             (full)
   );

   pattern_table i_pattern_table
   (
      .clk          (clk),
      .reset        (reset),
      .pred_addr    (pred_addr),
      .pred_ctr     (pred_ctr),
      .update_valid (branch_update_valid),
      .update_pc    (branch_update_pc),
      .update_taken (branch_taken),
      .table_ready  (table_ready)
   );

   fetch_queue #(.LG_ENTRIES(`LG_FQ_ENTRIES)) i_fetch_queue
   (
      .clk              (clk),
      .reset            (reset),
      .clear            (clear),
      .push             (push),
      .push_pc          (push_pc),
      .push_data        (push_data),
      .push_pred        (push_pred),
      .push_pred_target (push_pred_target),
      .full             (full),
      .insn_ack         (insn_ack),
      .insn_valid       (insn_valid),
      .insn_pc          (insn_pc),
      .insn_data        (insn_data),
      .insn_pred        (insn_pred),
      .insn_pred_target (insn_pred_target)
   );

endmodule

// ==== hw/pattern_table.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module pattern_table import fetch_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  addr_t    pred_addr,
   output pht_ctr_t pred_ctr,
   input  logic     update_valid,
   input  addr_t    update_pc,
   input  logic     update_taken,
   output logic     table_ready
);

   localparam int ENTRIES = 1 << `LG_PHT_ENTRIES;

   pht_ctr_t mem [0:ENTRIES-1];

   logic [`LG_PHT_ENTRIES-1:0] r_init_idx;
   logic [`LG_PHT_ENTRIES-1:0] t_pred_idx, t_upd_idx, r_upd_idx;
   logic                       r_init_busy, r_upd_valid, r_upd_taken;
   pht_ctr_t                   r_upd_ctr, t_upd_ctr;

   // index from the word address
   assign t_pred_idx = pred_addr[`LG_PHT_ENTRIES+1:2];
   assign t_upd_idx = update_pc[`LG_PHT_ENTRIES+1:2];
   assign table_ready = !r_init_busy;

   always_comb
   begin
      if (r_upd_taken)
      begin
         t_upd_ctr = (r_upd_ctr == 2'd3) ? r_upd_ctr : r_upd_ctr + 2'd1;
      end
      else
      begin
         t_upd_ctr = (r_upd_ctr == 2'd0) ? r_upd_ctr : r_upd_ctr - 2'd1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_init_busy <= 1'b1;
         r_init_idx <= '0;
         r_upd_valid <= 1'b0;
      end
      else
      begin
         if (r_init_busy)
         begin
            r_init_idx <= r_init_idx + 1'b1;
            r_init_busy <= ~&r_init_idx;
         end
         r_upd_valid <= update_valid;
      end
   end

   // init walk writes weakly not taken, then updates own the write port
   always_ff @(posedge clk)
   begin
      if (r_init_busy)
      begin
         mem[r_init_idx] <= 2'd1;
      end
      else if (r_upd_valid)
      begin
         mem[r_upd_idx] <= t_upd_ctr;
      end
      pred_ctr <= mem[t_pred_idx];
      // back-to-back updates to one entry see the pending write
      if (r_upd_valid && (r_upd_idx == t_upd_idx))
      begin
         r_upd_ctr <= t_upd_ctr;
      end
      else
      begin
         r_upd_ctr <= mem[t_upd_idx];
      end
      r_upd_idx <= t_upd_idx;
      r_upd_taken <= update_taken;
   end

endmodule

// ==== hw/predecode.sv ====
`timescale 1ns/1ps

module predecode import fetch_pkg::*;
(
   input  word_t     mem_word,
   output pd_class_t pd_class
);

   word_t insn;

   always_comb
   begin
      insn = byte_swap(mem_word);
      pd_class = pd_none;
      case (insn[31:26])
         // regimm, decoded on the rt field
         6'h01:
         begin
            case (insn[20:16])
               5'h00, 5'h01: pd_class = pd_cond;
               5'h02, 5'h03: pd_class = pd_likely;
               default: pd_class = pd_none;
            endcase
         end
         6'h02:
         begin
            pd_class = pd_jump;
         end
         6'h03:
         begin
            pd_class = pd_call;
         end
         // beq r0, r0 can never fall through
         6'h04:
         begin
            if ((insn[25:21] == 5'd0) && (insn[20:16] == 5'd0))
            begin
               pd_class = pd_always;
            end
            else
            begin
               pd_class = pd_cond;
            end
         end
         6'h05, 6'h06, 6'h07:
         begin
            pd_class = pd_cond;
         end
         // cop1 bc1f/bc1t, bit 17 selects the likely forms
         6'h11:
         begin
            if (insn[25:21] == 5'h08)
            begin
               pd_class = insn[17] ? pd_likely : pd_cond;
            end
         end
         6'h14, 6'h15, 6'h16, 6'h17:
         begin
            pd_class = pd_likely;
         end
         default:
         begin
            pd_class = pd_none;
         end
      endcase
   end

endmodule

// ==== hw/ram1r1w.sv ====
`timescale 1ns/1ps

module ram1r1w
#(
   parameter int WIDTH    = 32,
   parameter int LG_DEPTH = 6
)
(
   input  logic                clk,
   input  logic [LG_DEPTH-1:0] rd_addr,
   input  logic [LG_DEPTH-1:0] wr_addr,
   input  logic [WIDTH-1:0]    wr_data,
   input  logic                wr_en,
   output logic [WIDTH-1:0]    rd_data
);

   logic [WIDTH-1:0] mem [0:(1 << LG_DEPTH)-1];

   // a read that collides with a write returns the old contents
   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         mem[wr_addr] <= wr_data;
      end
      rd_data <= mem[rd_addr];
   end

endmodule
